// ==== verilog/bedrock_link_config.svh ====
`ifndef BEDROCK_LINK_CONFIG_SVH
`define BEDROCK_LINK_CONFIG_SVH

// link side.
`define LINK_FLIT_W 32
`define LINK_MSG_W 128
`define LINK_FLITS 4

// memory side.
`define MEM_DATA_W 64

// requests in flight toward memory.
`define CREDIT_MAX 8
`define CREDIT_W 4

`endif

// ==== verilog/bedrock_link_pkg.sv ====
`default_nettype none

`include "bedrock_link_config.svh"

package bedrock_link_pkg;

  // bedrock memory opcodes.
  typedef enum logic [3:0] {
    rd    = 4'b0000,
    wr    = 4'b0001,
    uc_rd = 4'b0010,
    uc_wr = 4'b0011,
    amo   = 4'b0101
  } mem_msg_e;

  typedef struct packed {
    mem_msg_e    msg_type;
    logic [3:0]  subop;
    logic [2:0]  size;
    logic [31:0] addr;
    logic [7:0]  lce_id;
    logic [7:0]  did;
  } mem_header_s;

  // byte aligned fields, msg_type in the lowest byte.
  localparam int unsigned aligned_pad_w = `LINK_MSG_W - 104;

  typedef struct packed {
    logic [aligned_pad_w-1:0] padding;
    logic [31:0]              data;
    logic [7:0]               lce_id;
    logic [7:0]               did;
    logic [31:0]              addr;
    logic [7:0]               size;
    logic [7:0]               subop;
    logic [7:0]               msg_type;
  } aligned_msg_s;

  // same word seen as fields or as link flits.
  typedef union packed {
    aligned_msg_s                              msg;
    logic [`LINK_FLITS-1:0][`LINK_FLIT_W-1:0] flits;  // flit 0 goes first.
  } aligned_word_u;

endpackage

`default_nettype wire

// ==== verilog/link_deserializer.sv ====
`default_nettype none

`include "bedrock_link_config.svh"

module link_deserializer (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,

  input  wire logic [`LINK_FLIT_W-1:0]       flit_i,
  input  wire logic                          flit_v_i,
  output logic                               flit_ready_o,

  output bedrock_link_pkg::aligned_word_u    word_o,
  output logic                               word_v_o,
  input  wire logic                          word_ready_i
);

  localparam int unsigned cnt_w = $clog2(`LINK_FLITS);

  logic [cnt_w-1:0]                cnt_q;
  logic                            full_q;
  bedrock_link_pkg::aligned_word_u shift_q;
  logic                            flit_take;
  logic                            word_take;

  assign flit_ready_o = ~full_q;  // stall while a word waits.
  assign word_v_o     = full_q;
  assign word_o       = shift_q;

  assign flit_take = flit_v_i & flit_ready_o;
  assign word_take = word_v_o & word_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else begin
      if (flit_take) begin
        if (cnt_q == cnt_w'(`LINK_FLITS - 1)) begin
          cnt_q  <= '0;
          full_q <= 1'b1;  // last flit in.
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
      if (word_take) begin
        full_q <= 1'b0;
      end
    end
  end

  // new flits enter at the top, so the first one ends in slot 0.
  always_ff @(posedge clk_i) begin
    if (flit_take) begin
      shift_q.flits <= {flit_i, shift_q.flits[`LINK_FLITS-1:1]};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/link_serializer.sv ====
`default_nettype none

`include "bedrock_link_config.svh"

module link_serializer (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,

  input  wire bedrock_link_pkg::aligned_word_u word_i,
  input  wire logic                            word_v_i,
  output logic                                 word_ready_o,

  output logic [`LINK_FLIT_W-1:0]              flit_o,
  output logic                                 flit_v_o,
  input  wire logic                            flit_ready_i
);

  localparam int unsigned idx_w = $clog2(`LINK_FLITS);

  bedrock_link_pkg::aligned_word_u word_q;
  logic [idx_w-1:0]                idx_q;
  logic                            busy_q;
  logic                            word_take;
  logic                            flit_take;

  assign word_ready_o = ~busy_q;  // one word at a time.
  assign flit_v_o     = busy_q;
  assign flit_o       = word_q.flits[idx_q];

  assign word_take = word_v_i & word_ready_o;
  assign flit_take = flit_v_o & flit_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (word_take) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (flit_take) begin
      if (idx_q == idx_w'(`LINK_FLITS - 1)) begin
        busy_q <= 1'b0;  // word drained.
        idx_q  <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_take) begin
      word_q <= word_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ack_return_queue.sv ====
`default_nettype none

module ack_return_queue (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,

  input  wire bedrock_link_pkg::mem_header_s hdr_i,
  input  wire logic                          hdr_v_i,
  output logic                               hdr_ready_o,

  output bedrock_link_pkg::mem_header_s      hdr_o,
  output logic                               hdr_v_o,
  input  wire logic                          hdr_ready_i
);

  bedrock_link_pkg::mem_header_s mem_q [2];
  logic                          wr_ptr_q;
  logic                          rd_ptr_q;
  logic [1:0]                    count_q;
  logic                          enq;
  logic                          deq;

  assign hdr_ready_o = (count_q != 2'd2);
  assign hdr_v_o     = (count_q != 2'd0);
  assign hdr_o       = mem_q[rd_ptr_q];

  assign enq = hdr_v_i & hdr_ready_o;
  assign deq = hdr_v_o & hdr_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (enq) wr_ptr_q <= ~wr_ptr_q;
      if (deq) rd_ptr_q <= ~rd_ptr_q;
      if (enq && !deq) count_q <= count_q + 2'd1;
      else if (deq && !enq) count_q <= count_q - 2'd1;  // both at once keeps count.
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_q[wr_ptr_q] <= hdr_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/credit_counter.sv ====
`default_nettype none

`include "bedrock_link_config.svh"

module credit_counter (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,

  input  wire logic                 send_i,
  input  wire logic                 return_i,

  output logic [`CREDIT_W-1:0]      credits_o
);

  logic [`CREDIT_W-1:0] count_q;

  assign credits_o = count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (send_i && !return_i) begin
      if (count_q != `CREDIT_W'(`CREDIT_MAX)) count_q <= count_q + 1'b1;  // saturate high.
    end else if (return_i && !send_i) begin
      if (count_q != '0) count_q <= count_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_endpoint_bridge.sv ====
`default_nettype none

`include "bedrock_link_config.svh"

module mem_endpoint_bridge (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,

  // link in, toward memory.
  input  wire logic [`LINK_FLIT_W-1:0]       fwd_flit_i,
  input  wire logic                          fwd_flit_v_i,
  output logic                               fwd_flit_ready_o,

  output bedrock_link_pkg::mem_header_s      mem_fwd_header_o,
  output logic [`MEM_DATA_W-1:0]             mem_fwd_data_o,
  output logic                               mem_fwd_v_o,
  input  wire logic                          mem_fwd_ready_i,

  // memory responses, back out the link.
  input  wire bedrock_link_pkg::mem_header_s mem_rev_header_i,
  input  wire logic [`MEM_DATA_W-1:0]        mem_rev_data_i,
  input  wire logic                          mem_rev_v_i,
  output logic                               mem_rev_ready_o,

  output logic [`LINK_FLIT_W-1:0]            rev_flit_o,
  output logic                               rev_flit_v_o,
  input  wire logic                          rev_flit_ready_i,

  // local requests, out the link.
  input  wire bedrock_link_pkg::mem_header_s mem_fwd_header_i,
  input  wire logic [`MEM_DATA_W-1:0]        mem_fwd_data_i,
  input  wire logic                          mem_fwd_v_i,
  output logic                               mem_fwd_ready_o,

  output logic [`LINK_FLIT_W-1:0]            fwd_flit_o,
  output logic                               fwd_flit_v_o,
  input  wire logic                          fwd_flit_ready_i,

  output bedrock_link_pkg::mem_header_s      mem_rev_header_o,
  output logic                               mem_rev_v_o,
  input  wire logic                          mem_rev_ready_i,

  output logic [`CREDIT_W-1:0]               credits_used_o
);

  // header plus low data word into the byte aligned link format.
  function automatic bedrock_link_pkg::aligned_word_u pack_msg(
    input bedrock_link_pkg::mem_header_s hdr,
    input logic [31:0]                   data
  );
    bedrock_link_pkg::aligned_word_u word;
    word.msg.padding  = '0;
    word.msg.data     = data;
    word.msg.lce_id   = hdr.lce_id;
    word.msg.did      = hdr.did;
    word.msg.addr     = hdr.addr;
    word.msg.size     = 8'(hdr.size);
    word.msg.subop    = 8'(hdr.subop);
    word.msg.msg_type = 8'(hdr.msg_type);
    return word;
  endfunction

  function automatic bedrock_link_pkg::mem_header_s unpack_hdr(
    input bedrock_link_pkg::aligned_msg_s msg
  );
    bedrock_link_pkg::mem_header_s hdr;
    hdr.msg_type = bedrock_link_pkg::mem_msg_e'(msg.msg_type[3:0]);
    hdr.subop    = msg.subop[3:0];
    hdr.size     = msg.size[2:0];
    hdr.addr     = msg.addr;
    hdr.lce_id   = msg.lce_id;
    hdr.did      = msg.did;
    return hdr;
  endfunction

  bedrock_link_pkg::aligned_word_u fwd_in_word;
  bedrock_link_pkg::aligned_word_u rev_word;
  bedrock_link_pkg::aligned_word_u fwd_out_word;
  logic                            rev_has_data;
  logic                            fwd_ser_ready;
  logic                            ack_q_ready;

  link_deserializer u_fwd_des (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flit_i      (fwd_flit_i),
    .flit_v_i    (fwd_flit_v_i),
    .flit_ready_o(fwd_flit_ready_o),
    .word_o      (fwd_in_word),
    .word_v_o    (mem_fwd_v_o),
    .word_ready_i(mem_fwd_ready_i)
  );

  assign mem_fwd_header_o = unpack_hdr(fwd_in_word.msg);
  assign mem_fwd_data_o   = {2{fwd_in_word.msg.data}};  // single word, both halves.

  // only responses with data go back over the link.
  assign rev_word     = pack_msg(mem_rev_header_i, mem_rev_data_i[31:0]);
  assign rev_has_data = mem_rev_header_i.msg_type inside
                        {bedrock_link_pkg::uc_rd, bedrock_link_pkg::rd, bedrock_link_pkg::amo};

  link_serializer u_rev_ser (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .word_i      (rev_word),
    .word_v_i    (mem_rev_v_i & rev_has_data),
    .word_ready_o(mem_rev_ready_o),
    .flit_o      (rev_flit_o),
    .flit_v_o    (rev_flit_v_o),
    .flit_ready_i(rev_flit_ready_i)
  );

  // request needs both the link and an ack slot.
  assign fwd_out_word    = pack_msg(mem_fwd_header_i, mem_fwd_data_i[31:0]);
  assign mem_fwd_ready_o = fwd_ser_ready & ack_q_ready;

  link_serializer u_fwd_ser (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .word_i      (fwd_out_word),
    .word_v_i    (mem_fwd_v_i & ack_q_ready),
    .word_ready_o(fwd_ser_ready),
    .flit_o      (fwd_flit_o),
    .flit_v_o    (fwd_flit_v_o),
    .flit_ready_i(fwd_flit_ready_i)
  );

  ack_return_queue u_ack_q (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .hdr_i      (mem_fwd_header_i),
    .hdr_v_i    (mem_fwd_v_i & fwd_ser_ready),
    .hdr_ready_o(ack_q_ready),
    .hdr_o      (mem_rev_header_o),
    .hdr_v_o    (mem_rev_v_o),
    .hdr_ready_i(mem_rev_ready_i)
  );

  credit_counter u_credits (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .send_i   (mem_fwd_v_o & mem_fwd_ready_i),
    .return_i (mem_rev_v_i & mem_rev_ready_o),  // write acks count too.
    .credits_o(credits_used_o)
  );

endmodule

`default_nettype wire

// ==== testbench/mem_endpoint_bridge_props.sv ====
`default_nettype none

`include "bedrock_link_config.svh"

module mem_endpoint_bridge_props (
  input wire logic                    clk_i,
  input wire logic                    rst_n_i,
  input wire logic [`LINK_FLIT_W-1:0] fwd_flit_o,
  input wire logic                    fwd_flit_v_o,
  input wire logic                    fwd_flit_ready_i,
  input wire logic [`LINK_FLIT_W-1:0] rev_flit_o,
  input wire logic                    rev_flit_v_o,
  input wire logic                    rev_flit_ready_i,
  input wire logic                    mem_fwd_v_o,
  input wire logic                    mem_rev_v_o,
  input wire logic [`CREDIT_W-1:0]    credits_used_o
);

  // a stalled flit holds until the link takes it.
  a_fwd_flit_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fwd_flit_v_o && !fwd_flit_ready_i |=> fwd_flit_v_o && $stable(fwd_flit_o))
    else $error("forward flit changed while stalled");

  a_rev_flit_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_flit_v_o && !rev_flit_ready_i |=> rev_flit_v_o && $stable(rev_flit_o))
    else $error("reverse flit changed while stalled");

  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_used_o <= `CREDIT_W'(`CREDIT_MAX))
    else $error("credit count above its maximum");

  a_reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> !(fwd_flit_v_o || rev_flit_v_o || mem_fwd_v_o || mem_rev_v_o)
                 && credits_used_o == '0)
    else $error("valid output or credit count not cleared by reset");

endmodule

`default_nettype wire

// ==== testbench/mem_endpoint_bridge_tb.sv ====
`default_nettype none

`include "bedrock_link_config.svh"

module mem_endpoint_bridge_tb;

  localparam int timeout_cycles = 50;
  localparam int c_fwd_ready = 0;
  localparam int c_fwd_flit  = 1;
  localparam int c_rev_ready = 2;
  localparam int c_rev_flit  = 3;
  localparam int c_mem_fwd_v = 4;
  localparam int c_ack_v     = 5;
  localparam int c_link_in   = 6;

  logic clk_i, rst_n_i;
  logic [`LINK_FLIT_W-1:0] fwd_flit_i, rev_flit_o, fwd_flit_o;
  logic fwd_flit_v_i, fwd_flit_ready_o, mem_fwd_v_o, mem_fwd_ready_i;
  logic mem_rev_v_i, mem_rev_ready_o, rev_flit_v_o, rev_flit_ready_i;
  logic mem_fwd_v_i, mem_fwd_ready_o, fwd_flit_v_o, fwd_flit_ready_i;
  logic mem_rev_v_o, mem_rev_ready_i;
  logic [`MEM_DATA_W-1:0] mem_fwd_data_o, mem_rev_data_i, mem_fwd_data_i;
  logic [`CREDIT_W-1:0] credits_used_o;
  bedrock_link_pkg::mem_header_s mem_fwd_header_o, mem_rev_header_i;
  bedrock_link_pkg::mem_header_s mem_fwd_header_i, mem_rev_header_o;

  int errors = 0;
  int timeouts = 0;
  logic [31:0] rng = 32'h4911;

  mem_endpoint_bridge u_mem_endpoint_bridge (.*);

  bind mem_endpoint_bridge mem_endpoint_bridge_props u_props (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift_next();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic bedrock_link_pkg::mem_header_s rand_header(
    input bedrock_link_pkg::mem_msg_e t
  );
    bedrock_link_pkg::mem_header_s h;
    logic [31:0] r;
    r = xorshift_next();
    h.msg_type = t;
    h.subop    = r[3:0];
    h.size     = r[6:4];
    h.lce_id   = r[15:8];
    h.did      = r[23:16];
    h.addr     = xorshift_next();
    return h;
  endfunction

  // byte lanes from msg_type at bit 0 up to the padding.
  function automatic logic [127:0] expect_word(
    input bedrock_link_pkg::mem_header_s h,
    input logic [31:0] data
  );
    return {24'h0, data, h.lce_id, h.did, h.addr, 5'h0, h.size, 4'h0, h.subop,
            4'h0, 4'(h.msg_type)};
  endfunction

  function automatic logic cond(input int which);
    case (which)
      c_fwd_ready: return mem_fwd_ready_o;
      c_fwd_flit:  return fwd_flit_v_o && fwd_flit_ready_i;
      c_rev_ready: return mem_rev_ready_o;
      c_rev_flit:  return rev_flit_v_o && rev_flit_ready_i;
      c_mem_fwd_v: return mem_fwd_v_o;
      c_ack_v:     return mem_rev_v_o;
      default:     return fwd_flit_ready_o;
    endcase
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic next_edge();
    @(posedge clk_i);
    #1;
  endtask

  // ends on a falling edge where the condition holds.
  task automatic wait_for(input int which, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!cond(which) && n < timeout_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (!cond(which)) begin
      timeouts++;
      $display("Timed out at %0t waiting for %s", $time, what);
    end
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
  endtask

  task automatic send_local(input bedrock_link_pkg::mem_header_s h, input logic [63:0] d);
    mem_fwd_header_i = h;
    mem_fwd_data_i   = d;
    mem_fwd_v_i      = 1'b1;
    wait_for(c_fwd_ready, "local request accept");
    next_edge();
    mem_fwd_v_i = 1'b0;
  endtask

  task automatic send_rev(input bedrock_link_pkg::mem_header_s h, input logic [63:0] d);
    mem_rev_header_i = h;
    mem_rev_data_i   = d;
    mem_rev_v_i      = 1'b1;
    wait_for(c_rev_ready, "memory response accept");
    next_edge();
    mem_rev_v_i = 1'b0;
  endtask

  task automatic send_link(input logic [127:0] word);
    for (int i = 0; i < `LINK_FLITS; i++) begin
      fwd_flit_i   = word[32*i +: 32];
      fwd_flit_v_i = 1'b1;
      wait_for(c_link_in, "incoming flit accept");
      next_edge();
    end
    fwd_flit_v_i = 1'b0;
  endtask

  task automatic collect_flits(input logic rev, output logic [127:0] word);
    for (int i = 0; i < `LINK_FLITS; i++) begin
      wait_for(rev ? c_rev_flit : c_fwd_flit, "outgoing flit");
      word[32*i +: 32] = rev ? rev_flit_o : fwd_flit_o;  // flit 0 first.
      next_edge();
    end
  endtask

  task automatic pop_ack();
    next_edge();
    mem_rev_ready_i = 1'b1;
    next_edge();
    mem_rev_ready_i = 1'b0;
  endtask

  // n link messages, each taken on the memory side.
  task automatic take_mem_fwd(input int n);
    mem_fwd_ready_i = 1'b1;
    repeat (n) begin
      send_link({xorshift_next(), xorshift_next(), xorshift_next(), xorshift_next()});
      wait_for(c_mem_fwd_v, "memory forward valid");
      next_edge();  // taken here.
    end
    mem_fwd_ready_i = 1'b0;
  endtask

  task automatic test_local_to_link();
    bedrock_link_pkg::mem_header_s h;
    logic [63:0] d;
    logic [127:0] word;
    h = rand_header(bedrock_link_pkg::wr);
    d = {xorshift_next(), xorshift_next()};
    mem_rev_ready_i = 1'b0;
    send_local(h, d);
    collect_flits(1'b0, word);
    if (word !== expect_word(h, d[31:0])) begin
      report_error($sformatf("forward word %h expected %h", word, expect_word(h, d[31:0])));
    end
    wait_for(c_ack_v, "local ack");
    if (mem_rev_header_o !== h) begin
      report_error($sformatf("ack header %h expected %h", mem_rev_header_o, h));
    end
    pop_ack();
  endtask

  task automatic test_link_to_mem();
    bedrock_link_pkg::mem_header_s h;
    logic [31:0] r;
    logic [31:0] d;
    r = xorshift_next();
    d = xorshift_next();
    h.msg_type = bedrock_link_pkg::uc_rd;
    h.subop    = r[6:3];
    h.size     = r[2:0];
    h.addr     = xorshift_next();
    h.lce_id   = r[31:24];
    h.did      = r[23:16];
    mem_fwd_ready_i = 1'b0;
    // upper bits of the widened bytes are junk to be dropped.
    send_link({24'h0, d, h.lce_id, h.did, h.addr, 5'h15, h.size, 4'ha, h.subop, 8'h92});
    wait_for(c_mem_fwd_v, "memory forward valid");
    if (mem_fwd_header_o !== h) begin
      report_error($sformatf("memory header %h expected %h", mem_fwd_header_o, h));
    end
    if (mem_fwd_data_o !== {d, d}) begin
      report_error($sformatf("memory data %h expected %h", mem_fwd_data_o, {d, d}));
    end
    if (fwd_flit_ready_o !== 1'b0) begin
      report_error($sformatf("link ready %b while a word is held", fwd_flit_ready_o));
    end
    next_edge();
    mem_fwd_ready_i = 1'b1;
    next_edge();
    mem_fwd_ready_i = 1'b0;
  endtask

  task automatic test_rev_filter();
    bedrock_link_pkg::mem_header_s h;
    logic [63:0] d;
    logic [127:0] word;
    for (int k = 0; k < 2; k++) begin
      h = rand_header(k == 0 ? bedrock_link_pkg::rd : bedrock_link_pkg::amo);
      d = {xorshift_next(), xorshift_next()};
      rev_flit_ready_i = (k == 0);  // atomic response meets a stalled link.
      send_rev(h, d);
      if (mem_rev_ready_o !== 1'b0) begin
        report_error($sformatf("response ready %b while serializing", mem_rev_ready_o));
      end
      if (k == 1) begin
        repeat (3) next_edge();
        rev_flit_ready_i = 1'b1;
      end
      collect_flits(1'b1, word);
      if (word !== expect_word(h, d[31:0])) begin
        report_error($sformatf("reverse word %h expected %h", word, expect_word(h, d[31:0])));
      end
    end
    send_rev(rand_header(bedrock_link_pkg::wr), {xorshift_next(), xorshift_next()});
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      if (rev_flit_v_o !== 1'b0) begin
        report_error($sformatf("reverse flit valid %b after write response", rev_flit_v_o));
      end
    end
    next_edge();
  endtask

  task automatic test_credits();
    apply_reset();
    take_mem_fwd(3);
    send_rev(rand_header(bedrock_link_pkg::wr), 64'h0);
    @(negedge clk_i);
    if (credits_used_o !== 4'd2) begin
      report_error($sformatf("credits %0d expected 2", credits_used_o));
    end
    next_edge();
    // ten in flight saturate the count.
    take_mem_fwd(`CREDIT_MAX);
    @(negedge clk_i);
    if (credits_used_o !== `CREDIT_W'(`CREDIT_MAX)) begin
      report_error($sformatf("credits %0d expected %0d", credits_used_o, `CREDIT_MAX));
    end
    next_edge();
  endtask

  task automatic test_backpressure();
    bedrock_link_pkg::mem_header_s h1;
    bedrock_link_pkg::mem_header_s h2;
    logic [127:0] word;
    fwd_flit_ready_i = 1'b0;
    mem_rev_ready_i  = 1'b1;
    send_local(rand_header(bedrock_link_pkg::rd), {xorshift_next(), xorshift_next()});
    @(negedge clk_i);
    if (mem_fwd_ready_o !== 1'b0) begin
      report_error($sformatf("request ready %b with link stalled", mem_fwd_ready_o));
    end
    next_edge();
    fwd_flit_ready_i = 1'b1;
    wait_for(c_fwd_ready, "request ready after flits drain");
    next_edge();
    mem_rev_ready_i = 1'b0;
    h1 = rand_header(bedrock_link_pkg::wr);
    h2 = rand_header(bedrock_link_pkg::uc_wr);
    send_local(h1, {xorshift_next(), xorshift_next()});
    collect_flits(1'b0, word);
    send_local(h2, {xorshift_next(), xorshift_next()});
    collect_flits(1'b0, word);
    repeat (3) begin
      @(negedge clk_i);
      if (mem_fwd_ready_o !== 1'b0) begin
        report_error($sformatf("request ready %b with two acks held", mem_fwd_ready_o));
      end
    end
    if (mem_rev_v_o !== 1'b1 || mem_rev_header_o !== h1) begin
      report_error($sformatf("oldest ack %h expected %h", mem_rev_header_o, h1));
    end
    pop_ack();
    @(negedge clk_i);
    if (mem_fwd_ready_o !== 1'b1) begin
      report_error($sformatf("request ready %b after one ack taken", mem_fwd_ready_o));
    end
    if (mem_rev_header_o !== h2) begin
      report_error($sformatf("second ack %h expected %h", mem_rev_header_o, h2));
    end
    pop_ack();
  endtask

  initial begin
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    fwd_flit_i       = '0;
    fwd_flit_v_i     = 1'b0;
    mem_fwd_ready_i  = 1'b0;
    mem_rev_header_i = '0;
    mem_rev_data_i   = '0;
    mem_rev_v_i      = 1'b0;
    rev_flit_ready_i = 1'b1;
    mem_fwd_header_i = '0;
    mem_fwd_data_i   = '0;
    mem_fwd_v_i      = 1'b0;
    fwd_flit_ready_i = 1'b1;
    mem_rev_ready_i  = 1'b0;
    apply_reset();
    test_local_to_link();
    test_link_to_mem();
    test_rev_filter();
    test_credits();
    test_backpressure();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verilog
verilog/bedrock_link_pkg.sv
verilog/link_deserializer.sv
verilog/link_serializer.sv
verilog/ack_return_queue.sv
verilog/credit_counter.sv
verilog/mem_endpoint_bridge.sv
testbench/mem_endpoint_bridge_props.sv
testbench/mem_endpoint_bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the bridge testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module mem_endpoint_bridge_tb -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmem_endpoint_bridge_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
